//--- hdl/datapathPkg.sv
// Shared sizes, ALU operation codes, control word and instruction field layout for the datapath
package datapathPkg;

   localparam int WordWidth = 32;
   localparam int RegCount = 16;
   localparam int RegIndexWidth = 4;
   localparam int MemDepth = 512;
   localparam int MemAddrWidth = 9;

   typedef logic [WordWidth-1:0] word;

   typedef enum logic [3:0] {
      opAdd,
      opSub,
      opAnd,
      opOr,
      opShl,
      opShr,
      opNeg,
      opNot,
      opMul,
      opDiv
   } aluOp;

   // One-hot bus drivers, at most one high per cycle
   typedef struct packed {
      logic rfOut;
      logic pcOut;
      logic irOut;
      logic ryOut;
      logic rzLoOut;
      logic rzHiOut;
      logic marOut;
      logic rhiOut;
      logic rloOut;
      logic immOut;
      logic mdrOut;
      logic extOut;
   } busSources;

   typedef struct packed {
      logic rfIn;
      logic pcIn;
      logic irIn;
      logic ryIn;
      logic rzIn;
      logic marIn;
      logic rhiIn;
      logic rloIn;
      logic mdrIn;
      logic conIn;
   } registerLoads;

   typedef struct packed {
      busSources source;
      registerLoads load;
      logic gra;
      logic grb;
      logic grc;
      logic baOut;
      logic incPc;
      logic read;
      logic write;
      logic start;
      aluOp op;
   } controlWord;

   // The low 19 bits are read three ways depending on the instruction format
   typedef struct packed {
      logic [3:0] rc;
      logic [14:0] spare;
   } rcView;

   typedef struct packed {
      logic [16:0] spare;
      logic [1:0] c2;
   } condView;

   typedef union packed {
      logic [18:0] constant;
      rcView rcField;
      condView condField;
   } lowField;

   typedef struct packed {
      logic [4:0] opcode;
      logic [RegIndexWidth-1:0] ra;
      logic [RegIndexWidth-1:0] rb;
      lowField low;
   } instrFields;

endpackage

//--- hdl/registerFile.sv
// General register file with sixteen words, one read port, one write port and a zeroable R0
`timescale 1ns/1ps

module registerFile (
   input  logic Clock,
   input  logic reset,
   input  logic [datapathPkg::RegIndexWidth-1:0] index,
   input  logic writeEnable,
   input  logic zeroR0,
   input  datapathPkg::word writeData,
   output datapathPkg::word readData
);

   datapathPkg::word regs [datapathPkg::RegCount];
   logic isR0;

   // Contents survive reset, only writes are held off while it is asserted
   always_ff @(posedge Clock) begin
      if (writeEnable && !reset) begin
         regs[index] <= writeData;
      end
   end

   assign isR0 = (index == '0);

   // Base-address mode reads R0 as a literal zero
   always_comb begin
      if (zeroR0 && isR0) begin
         readData = '0;
      end else begin
         readData = regs[index];
      end
   end

endmodule

//--- hdl/instructionDecode.sv
// Instruction field decode with register select, immediate sign extension and condition flag
`timescale 1ns/1ps

module instructionDecode (
   input  logic Clock,
   input  logic reset,
   input  datapathPkg::instrFields ir,
   input  datapathPkg::controlWord ctrl,
   input  datapathPkg::word bus,
   output logic [datapathPkg::RegIndexWidth-1:0] regIndex,
   output datapathPkg::word immValue,
   output logic conFlag
);

   localparam int ConstWidth = 19;

   logic condMet;
   logic busZero;
   logic busNegative;

   // Gra takes priority when the sequencer raises more than one select
   always_comb begin
      if (ctrl.gra) begin
         regIndex = ir.ra;
      end else if (ctrl.grb) begin
         regIndex = ir.rb;
      end else if (ctrl.grc) begin
         regIndex = ir.low.rcField.rc;
      end else begin
         regIndex = '0;
      end
   end

   assign immValue = {{(datapathPkg::WordWidth - ConstWidth){ir.low.constant[ConstWidth-1]}},
                      ir.low.constant};

   assign busZero = (bus == '0);
   assign busNegative = bus[datapathPkg::WordWidth-1];

   // Branch condition codes from c2
   always_comb begin
      case (ir.low.condField.c2)
         2'd0: condMet = busZero;
         2'd1: condMet = !busZero;
         2'd2: condMet = !busNegative;
         default: condMet = busNegative;
      endcase
   end

   always_ff @(posedge Clock) begin
      if (reset) begin
         conFlag <= 1'b0;
      end else if (ctrl.load.conIn) begin
         conFlag <= condMet;
      end
   end

endmodule

//--- hdl/arithLogicUnit.sv
// ALU with single-cycle logic and arithmetic plus iterative signed multiply and divide
`timescale 1ns/1ps

module arithLogicUnit (
   input  logic Clock,
   input  logic reset,
   input  logic start,
   input  datapathPkg::aluOp op,
   input  datapathPkg::word a,
   input  datapathPkg::word b,
   output logic [2*datapathPkg::WordWidth-1:0] result,
   output logic finished
);

   localparam int W = datapathPkg::WordWidth;

   typedef enum logic [1:0] {stIdle, stMul, stDiv} aluState;

   aluState state;
   logic [W-1:0] acc;
   logic [W-1:0] work;
   logic [W-1:0] operand;
   logic [5:0] count;
   logic negLow;
   logic negHigh;

   logic [W-1:0] absA;
   logic [W-1:0] absB;
   logic [W-1:0] simple;
   logic [W:0] mulSum;
   logic [W-1:0] mulAccNext;
   logic [W-1:0] mulWorkNext;
   logic [2*W-1:0] product;
   logic [W:0] divShift;
   logic [W:0] divTrial;
   logic [W-1:0] divAccNext;
   logic [W-1:0] divWorkNext;
   logic [W-1:0] quotient;
   logic [W-1:0] remainder;

   always_comb begin
      absA = a[W-1] ? -a : a;
      absB = b[W-1] ? -b : b;

      // Unary ops work on the bus operand
      case (op)
         datapathPkg::opAdd: simple = a + b;
         datapathPkg::opSub: simple = a - b;
         datapathPkg::opAnd: simple = a & b;
         datapathPkg::opOr:  simple = a | b;
         datapathPkg::opShl: simple = a << b[4:0];
         datapathPkg::opShr: simple = a >> b[4:0];
         datapathPkg::opNeg: simple = -b;
         default:            simple = ~b;
      endcase

      // One shift-and-add step on the upper half held in acc
      mulSum = {1'b0, acc} + (work[0] ? {1'b0, operand} : '0);
      mulAccNext = mulSum[W:1];
      mulWorkNext = {mulSum[0], work[W-1:1]};
      product = negLow ? -{mulAccNext, mulWorkNext} : {mulAccNext, mulWorkNext};

      // Restoring division step
      divShift = {acc, work[W-1]};
      divTrial = divShift - {1'b0, operand};
      divAccNext = divTrial[W] ? divShift[W-1:0] : divTrial[W-1:0];
      divWorkNext = {work[W-2:0], ~divTrial[W]};
      quotient = negLow ? -divWorkNext : divWorkNext;
      remainder = negHigh ? -divAccNext : divAccNext;
   end

   always_ff @(posedge Clock) begin
      if (reset) begin
         state <= stIdle;
         finished <= 1'b0;
         count <= '0;
         negLow <= 1'b0;
         negHigh <= 1'b0;
      end else begin
         finished <= 1'b0;
         case (state)
            stIdle: begin
               if (start) begin
                  count <= '0;
                  acc <= '0;
                  negLow <= a[W-1] ^ b[W-1];
                  negHigh <= a[W-1];
                  if (op == datapathPkg::opMul) begin
                     operand <= absA;
                     work <= absB;
                     state <= stMul;
                  end else if (op == datapathPkg::opDiv) begin
                     if (b == '0) begin
                        // A zero divisor gives all ones and leaves the dividend as remainder
                        result <= {a, {W{1'b1}}};
                        finished <= 1'b1;
                     end else begin
                        operand <= absB;
                        work <= absA;
                        state <= stDiv;
                     end
                  end else begin
                     result <= {{W{1'b0}}, simple};
                     finished <= 1'b1;
                  end
               end
            end
            stMul: begin
               acc <= mulAccNext;
               work <= mulWorkNext;
               count <= count + 6'd1;
               if (count == 6'(W - 1)) begin
                  result <= product;
                  finished <= 1'b1;
                  state <= stIdle;
               end
            end
            default: begin
               acc <= divAccNext;
               work <= divWorkNext;
               count <= count + 6'd1;
               if (count == 6'(W - 1)) begin
                  result <= {remainder, quotient};
                  finished <= 1'b1;
                  state <= stIdle;
               end
            end
         endcase
      end
   end

endmodule

//--- hdl/memoryUnit.sv
// Word memory behind MAR and MDR with strobed read and write and a completion pulse
`timescale 1ns/1ps

module memoryUnit (
   input  logic Clock,
   input  logic reset,
   input  datapathPkg::controlWord ctrl,
   input  datapathPkg::word bus,
   output datapathPkg::word mdrValue,
   output datapathPkg::word marValue,
   output logic memFinished
);

   datapathPkg::word mem [datapathPkg::MemDepth];
   logic [datapathPkg::MemAddrWidth-1:0] addr;

   // Only the low address bits reach the array
   assign addr = marValue[datapathPkg::MemAddrWidth-1:0];

   always_ff @(posedge Clock) begin
      if (reset) begin
         marValue <= '0;
         mdrValue <= '0;
         memFinished <= 1'b0;
      end else begin
         memFinished <= ctrl.read | ctrl.write;
         if (ctrl.load.marIn) begin
            marValue <= bus;
         end
         // A read together with mdrIn takes memory data, otherwise MDR takes the bus
         if (ctrl.load.mdrIn) begin
            if (ctrl.read) begin
               mdrValue <= mem[addr];
            end else begin
               mdrValue <= bus;
            end
         end
      end
   end

   always_ff @(posedge Clock) begin
      if (ctrl.write) begin
         mem[addr] <= mdrValue;
      end
   end

endmodule

//--- hdl/busFabric.sv
// Special registers of the datapath and the single shared bus multiplexer
`timescale 1ns/1ps

module busFabric (
   input  logic Clock,
   input  logic reset,
   input  datapathPkg::controlWord ctrl,
   input  datapathPkg::word rfValue,
   input  datapathPkg::word mdrValue,
   input  datapathPkg::word marValue,
   input  datapathPkg::word immValue,
   input  datapathPkg::word externalIn,
   input  logic [2*datapathPkg::WordWidth-1:0] aluResult,
   input  logic aluFinished,
   output datapathPkg::word bus,
   output datapathPkg::word yValue,
   output datapathPkg::instrFields ir
);

   localparam int W = datapathPkg::WordWidth;

   datapathPkg::word pc;
   datapathPkg::word hi;
   datapathPkg::word lo;
   logic [2*W-1:0] z;
   datapathPkg::busSources src;

   assign src = ctrl.source;

   // Sources are one-hot so an AND-OR tree is enough, and idle bus reads zero
   assign bus = ({W{src.rfOut}} & rfValue)
              | ({W{src.pcOut}} & pc)
              | ({W{src.irOut}} & W'(ir))
              | ({W{src.ryOut}} & yValue)
              | ({W{src.rzLoOut}} & z[W-1:0])
              | ({W{src.rzHiOut}} & z[2*W-1:W])
              | ({W{src.marOut}} & marValue)
              | ({W{src.rhiOut}} & hi)
              | ({W{src.rloOut}} & lo)
              | ({W{src.immOut}} & immValue)
              | ({W{src.mdrOut}} & mdrValue)
              | ({W{src.extOut}} & externalIn);

   always_ff @(posedge Clock) begin
      if (reset) begin
         pc <= '0;
         ir <= '0;
         yValue <= '0;
         z <= '0;
         hi <= '0;
         lo <= '0;
      end else begin
         // A direct PC load wins over the increment
         if (ctrl.load.pcIn) begin
            pc <= bus;
         end else if (ctrl.incPc) begin
            pc <= pc + W'(1);
         end
         if (ctrl.load.irIn) begin
            ir <= bus;
         end
         if (ctrl.load.ryIn) begin
            yValue <= bus;
         end
         // Z waits for the ALU pulse, rzIn is held until then
         if (ctrl.load.rzIn && aluFinished) begin
            z <= aluResult;
         end
         if (ctrl.load.rhiIn) begin
            hi <= bus;
         end
         if (ctrl.load.rloIn) begin
            lo <= bus;
         end
      end
   end

endmodule

//--- hdl/dataPath.sv
// Top level of the single-bus datapath, all blocks wired around the shared bus
`timescale 1ns/1ps

module dataPath (
   input  logic Clock,
   input  logic reset,
   input  datapathPkg::controlWord ctrl,
   input  datapathPkg::word externalIn,
   output datapathPkg::word busValue,
   output logic conFlag,
   output logic aluFinished,
   output logic memFinished
);

   datapathPkg::word rfValue;
   datapathPkg::word mdrValue;
   datapathPkg::word marValue;
   datapathPkg::word immValue;
   datapathPkg::word yValue;
   datapathPkg::instrFields ir;
   logic [datapathPkg::RegIndexWidth-1:0] regIndex;
   logic [2*datapathPkg::WordWidth-1:0] aluResult;

   registerFile regFile (
      .Clock(Clock),
      .reset(reset),
      .index(regIndex),
      .writeEnable(ctrl.load.rfIn),
      .zeroR0(ctrl.baOut),
      .writeData(busValue),
      .readData(rfValue)
   );

   instructionDecode decode (
      .Clock(Clock),
      .reset(reset),
      .ir(ir),
      .ctrl(ctrl),
      .bus(busValue),
      .regIndex(regIndex),
      .immValue(immValue),
      .conFlag(conFlag)
   );

   // Y feeds the first operand, the bus the second
   arithLogicUnit alu (
      .Clock(Clock),
      .reset(reset),
      .start(ctrl.start),
      .op(ctrl.op),
      .a(yValue),
      .b(busValue),
      .result(aluResult),
      .finished(aluFinished)
   );

   memoryUnit memory (
      .Clock(Clock),
      .reset(reset),
      .ctrl(ctrl),
      .bus(busValue),
      .mdrValue(mdrValue),
      .marValue(marValue),
      .memFinished(memFinished)
   );

   busFabric fabric (
      .Clock(Clock),
      .reset(reset),
      .ctrl(ctrl),
      .rfValue(rfValue),
      .mdrValue(mdrValue),
      .marValue(marValue),
      .immValue(immValue),
      .externalIn(externalIn),
      .aluResult(aluResult),
      .aluFinished(aluFinished),
      .bus(busValue),
      .yValue(yValue),
      .ir(ir)
   );

endmodule

//--- test/dataPathTb.sv
// Sequencer testbench for the datapath that replays microsequences per vector and checks the bus
`timescale 1ns/1ps

module dataPathTb;

   localparam int VecFields = 7;
   localparam int MaxVectors = 48;
   localparam int WaitLimit = 50;
   localparam int RandomTests = 4;
   localparam int SelA = 0;
   localparam int SelB = 1;
   localparam int SelC = 2;
   // ra = 1, rb = 2, rc = 3 with the ALU code in the opcode field
   localparam logic [31:0] AddInstr = 32'h00918000;
   localparam logic [31:0] MulInstr = 32'h40918000;

   logic Clock;
   logic reset;
   datapathPkg::controlWord ctrl;
   datapathPkg::word externalIn;
   datapathPkg::word busValue;
   logic conFlag;
   logic aluFinished;
   logic memFinished;

   logic [31:0] vecMem [VecFields*MaxVectors];
   int errors;
   int passes;
   int testCount;
   int seed;
   bit testFailed;

   dataPath DUT (
      .Clock(Clock),
      .reset(reset),
      .ctrl(ctrl),
      .externalIn(externalIn),
      .busValue(busValue),
      .conFlag(conFlag),
      .aluFinished(aluFinished),
      .memFinished(memFinished)
   );

   initial begin
      Clock = 1'b0;
      forever begin
         #2 Clock = ~Clock;
      end
   end

   // Every control cycle begins at a falling edge with all strobes low
   task automatic nextCycle();
      @(negedge Clock);
      ctrl = '0;
   endtask

   task automatic selectReg(input int sel);
      case (sel)
         SelA: ctrl.gra = 1'b1;
         SelB: ctrl.grb = 1'b1;
         default: ctrl.grc = 1'b1;
      endcase
   endtask

   // Bus settles well before the next rising edge
   task automatic sampleBus(output datapathPkg::word value);
      #1;
      value = busValue;
   endtask

   task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("MISMATCH at %0t: test %0d %s is %h, expected %h",
                  $time, testCount, what, got, exp);
         testFailed = 1'b1;
      end
   endtask

   task automatic reportTimeout(input string what);
      $display("timeout waiting for %s in test %0d at %0t", what, testCount, $time);
      testFailed = 1'b1;
   endtask

   task automatic waitAlu(output int latency);
      bit seen;
      latency = 0;
      seen = 1'b0;
      while (!seen && latency < WaitLimit) begin
         nextCycle();
         // Z takes the result on the edge closing the finished cycle
         ctrl.load.rzIn = 1'b1;
         seen = aluFinished;
         latency++;
      end
      if (!seen) begin
         reportTimeout("aluFinished");
      end
   endtask

   task automatic waitMem(output int latency);
      bit seen;
      latency = 0;
      seen = 1'b0;
      while (!seen && latency < WaitLimit) begin
         nextCycle();
         seen = memFinished;
         latency++;
      end
      if (!seen) begin
         reportTimeout("memFinished");
      end
   endtask

   task automatic loadIr(input logic [31:0] instr);
      nextCycle();
      externalIn = instr;
      ctrl.source.extOut = 1'b1;
      ctrl.load.irIn = 1'b1;
   endtask

   task automatic writeReg(input int sel, input logic [31:0] value);
      nextCycle();
      externalIn = value;
      ctrl.source.extOut = 1'b1;
      ctrl.load.rfIn = 1'b1;
      selectReg(sel);
   endtask

   task automatic readReg(input int sel, output datapathPkg::word value);
      nextCycle();
      ctrl.source.rfOut = 1'b1;
      selectReg(sel);
      sampleBus(value);
   endtask

   // Operand A goes through rb into Y while the second operand drives the bus with start
   task automatic aluThroughZ(input logic [31:0] instr, input logic [31:0] a,
                              input logic [31:0] b, input bit immediate);
      datapathPkg::instrFields fields;
      int latency;
      bit multiCycle;
      fields = instr;
      loadIr(instr);
      writeReg(SelB, a);
      if (!immediate) begin
         writeReg(SelC, b);
      end
      nextCycle();
      ctrl.source.rfOut = 1'b1;
      ctrl.grb = 1'b1;
      ctrl.baOut = immediate;
      ctrl.load.ryIn = 1'b1;
      nextCycle();
      ctrl.start = 1'b1;
      if (immediate) begin
         ctrl.source.immOut = 1'b1;
         ctrl.op = datapathPkg::opAdd;
      end else begin
         ctrl.source.rfOut = 1'b1;
         ctrl.grc = 1'b1;
         ctrl.op = datapathPkg::aluOp'(fields.opcode[3:0]);
      end
      multiCycle = (ctrl.op == datapathPkg::opMul) || (ctrl.op == datapathPkg::opDiv);
      waitAlu(latency);
      // Single-step operations finish in the cycle right after start
      if (!multiCycle) begin
         checkValue("ALU latency", latency, 1);
      end
   endtask

   task automatic storeZLow();
      nextCycle();
      ctrl.source.rzLoOut = 1'b1;
      ctrl.gra = 1'b1;
      ctrl.load.rfIn = 1'b1;
   endtask

   task automatic regRegOp(input logic [31:0] instr, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] expLo);
      datapathPkg::word got;
      aluThroughZ(instr, a, b, 1'b0);
      storeZLow();
      readReg(SelA, got);
      checkValue("ra", got, expLo);
   endtask

   task automatic addImmediate(input logic [31:0] instr, input logic [31:0] a,
                               input logic [31:0] expLo);
      datapathPkg::word got;
      aluThroughZ(instr, a, '0, 1'b1);
      storeZLow();
      readReg(SelA, got);
      checkValue("ra", got, expLo);
   endtask

   task automatic mulDiv(input logic [31:0] instr, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] expLo, input logic [31:0] expHi);
      datapathPkg::word got;
      aluThroughZ(instr, a, b, 1'b0);
      nextCycle();
      ctrl.source.rzHiOut = 1'b1;
      ctrl.load.rhiIn = 1'b1;
      nextCycle();
      ctrl.source.rzLoOut = 1'b1;
      ctrl.load.rloIn = 1'b1;
      nextCycle();
      ctrl.source.rhiOut = 1'b1;
      sampleBus(got);
      checkValue("HI", got, expHi);
      nextCycle();
      ctrl.source.rloOut = 1'b1;
      sampleBus(got);
      checkValue("LO", got, expLo);
   endtask

   task automatic storeAndLoad(input logic [31:0] instr, input logic [31:0] addr,
                               input logic [31:0] data);
      datapathPkg::word got;
      int latency;
      loadIr(instr);
      nextCycle();
      externalIn = addr;
      ctrl.source.extOut = 1'b1;
      ctrl.load.marIn = 1'b1;
      nextCycle();
      externalIn = data;
      ctrl.source.extOut = 1'b1;
      ctrl.load.mdrIn = 1'b1;
      nextCycle();
      ctrl.write = 1'b1;
      waitMem(latency);
      checkValue("write latency", latency, 1);
      // Scramble MDR so the readback has to come from the array
      nextCycle();
      externalIn = ~data;
      ctrl.source.extOut = 1'b1;
      ctrl.load.mdrIn = 1'b1;
      nextCycle();
      ctrl.read = 1'b1;
      ctrl.load.mdrIn = 1'b1;
      waitMem(latency);
      checkValue("read latency", latency, 1);
      nextCycle();
      ctrl.source.mdrOut = 1'b1;
      ctrl.gra = 1'b1;
      ctrl.load.rfIn = 1'b1;
      readReg(SelA, got);
      checkValue("loaded word", got, data);
      nextCycle();
      ctrl.source.marOut = 1'b1;
      sampleBus(got);
      checkValue("MAR", got, addr);
   endtask

   task automatic conditionFlag(input logic [31:0] instr, input logic [31:0] a,
                                input logic [31:0] expFlag);
      loadIr(instr);
      writeReg(SelA, a);
      nextCycle();
      ctrl.source.rfOut = 1'b1;
      ctrl.gra = 1'b1;
      ctrl.load.conIn = 1'b1;
      nextCycle();
      checkValue("conFlag", {31'b0, conFlag}, expFlag);
   endtask

   task automatic pcIncrement(input logic [31:0] loadValue, input logic [31:0] count,
                              input logic [31:0] expLo);
      datapathPkg::word got;
      nextCycle();
      externalIn = loadValue;
      ctrl.source.extOut = 1'b1;
      ctrl.load.pcIn = 1'b1;
      repeat (count) begin
         nextCycle();
         ctrl.incPc = 1'b1;
      end
      nextCycle();
      ctrl.source.pcOut = 1'b1;
      sampleBus(got);
      checkValue("PC", got, expLo);
   endtask

   task automatic beginTest();
      testCount++;
      testFailed = 1'b0;
   endtask

   task automatic endTest(input string name);
      if (testFailed) begin
         errors++;
         $display("test %0d %s: FAIL", testCount, name);
      end else begin
         passes++;
         $display("test %0d %s: pass", testCount, name);
      end
   endtask

   initial begin
      int index;
      int base;
      string name;
      logic [31:0] kind;
      logic [31:0] instr;
      logic [31:0] opA;
      logic [31:0] opB;
      logic [31:0] expLo;
      logic [31:0] expHi;
      logic [31:0] expFlag;
      logic signed [63:0] wideA;
      logic signed [63:0] wideB;
      logic signed [63:0] product;
      datapathPkg::word got;

      reset = 1'b1;
      ctrl = '0;
      externalIn = '0;
      errors = 0;
      passes = 0;
      testCount = 0;
      seed = 49649;
      for (int i = 0; i < VecFields*MaxVectors; i++) begin
         vecMem[i] = '0;
      end
      $readmemh("test/dataPathVectors.txt", vecMem);

      repeat (2) begin
         @(posedge Clock);
      end
      @(negedge Clock);
      reset = 1'b0;

      beginTest();
      nextCycle();
      ctrl.source.pcOut = 1'b1;
      sampleBus(got);
      checkValue("PC after reset", got, '0);
      checkValue("aluFinished after reset", {31'b0, aluFinished}, '0);
      checkValue("memFinished after reset", {31'b0, memFinished}, '0);
      checkValue("conFlag after reset", {31'b0, conFlag}, '0);
      endTest("reset state");

      // A zero kind marks the end of the table
      index = 0;
      while (index < MaxVectors && vecMem[index*VecFields] != '0) begin
         base = index*VecFields;
         kind = vecMem[base];
         instr = vecMem[base+1];
         opA = vecMem[base+2];
         opB = vecMem[base+3];
         expLo = vecMem[base+4];
         expHi = vecMem[base+5];
         expFlag = vecMem[base+6];
         beginTest();
         case (kind)
            1: begin
               name = "alu reg-reg";
               regRegOp(instr, opA, opB, expLo);
            end
            2: begin
               name = "addi";
               addImmediate(instr, opA, expLo);
            end
            3: begin
               name = "mul/div";
               mulDiv(instr, opA, opB, expLo, expHi);
            end
            4: begin
               name = "memory";
               storeAndLoad(instr, opA, opB);
            end
            5: begin
               name = "condition";
               conditionFlag(instr, opA, expFlag);
            end
            6: begin
               name = "pc increment";
               pcIncrement(opA, opB, expLo);
            end
            default: begin
               name = "unknown";
               $display("test %0d has an unknown sequence kind %0h", testCount, kind);
               testFailed = 1'b1;
            end
         endcase
         endTest(name);
         index++;
      end
      if (index == 0) begin
         $display("the vector file gave no tests");
         errors++;
      end

      for (int i = 0; i < RandomTests; i++) begin
         opA = $random(seed);
         opB = $random(seed);
         beginTest();
         regRegOp(AddInstr, opA, opB, opA + opB);
         endTest("random add");
         wideA = {{32{opA[31]}}, opA};
         wideB = {{32{opB[31]}}, opB};
         product = wideA * wideB;
         beginTest();
         mulDiv(MulInstr, opA, opB, product[31:0], product[63:32]);
         endTest("random mul");
      end

      $display("%0d tests run, %0d passed, %0d failed", testCount, passes, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

//--- test/dataPathVectors.txt
// kind instr a b expLo expHi flag, all hex; kinds 1 alu, 2 addi, 3 mul/div, 4 memory
// 5 condition (c2 in instr), 6 pc (a = load value, b = increments); ALU code in opcode bits
1 00918000 00000005 00000007 0000000C 00000000 0
1 00918000 FFFFFFFF 00000002 00000001 00000000 0
1 08918000 00000010 00000025 FFFFFFEB 00000000 0
1 10918000 F0F0F0F0 FF00FF00 F000F000 00000000 0
1 18918000 12340000 00005678 12345678 00000000 0
1 20918000 00000003 00000004 00000030 00000000 0
1 20918000 00000001 00000021 00000002 00000000 0
1 28918000 80000000 0000001F 00000001 00000000 0
1 30918000 00000000 00000005 FFFFFFFB 00000000 0
1 38918000 00000000 0F0F0F0F F0F0F0F0 00000000 0
2 0207FFFF 0000ABCD 00000000 FFFFFFFF 00000000 0
2 02000123 12345678 00000000 00000123 00000000 0
2 02280010 00000100 00000000 00000110 00000000 0
2 022C0000 00050000 00000000 00010000 00000000 0
3 40918000 00000007 00000006 0000002A 00000000 0
3 40918000 FFFFFFFD 00000005 FFFFFFF1 FFFFFFFF 0
3 40918000 00010000 00010000 00000000 00000001 0
3 40918000 80000000 00000002 00000000 FFFFFFFF 0
3 40918000 FFFFFFFF FFFFFFFF 00000001 00000000 0
3 48918000 00000064 00000007 0000000E 00000002 0
3 48918000 FFFFFF9C 00000007 FFFFFFF2 FFFFFFFE 0
3 48918000 00000064 FFFFFFF9 FFFFFFF2 00000002 0
3 48918000 00001234 00000000 FFFFFFFF 00001234 0
4 03000000 00000010 DEADBEEF DEADBEEF 00000000 0
4 03000000 000001FF 13572468 13572468 00000000 0
5 03800000 00000000 00000000 00000000 00000000 1
5 03800000 00000001 00000000 00000000 00000000 0
5 03800001 00000000 00000000 00000000 00000000 0
5 03800001 80000000 00000000 00000000 00000000 1
5 03800002 00000000 00000000 00000000 00000000 1
5 03800002 FFFFFFFF 00000000 00000000 00000000 0
5 03800003 80000001 00000000 00000000 00000000 1
5 03800003 7FFFFFFF 00000000 00000000 00000000 0
6 00000000 00000100 00000005 00000105 00000000 0
6 00000000 FFFFFFFE 00000003 00000001 00000000 0

//--- src.f
hdl/datapathPkg.sv
hdl/registerFile.sv
hdl/instructionDecode.sv
hdl/arithLogicUnit.sv
hdl/memoryUnit.sv
hdl/busFabric.sv
hdl/dataPath.sv
test/dataPathTb.sv

//--- run.sh
#!/bin/sh
# Build the datapath testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module dataPathTb -f src.f -o dataPathSim
simOutput=$(./obj_dir/dataPathSim)
echo "$simOutput"
echo "$simOutput" | grep -qx "No errors"
